// File: Makefile
VERILATOR  ?= verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
TOP        := dcache_tb
FILELIST   := dcache_top.f
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dcache_top.f
+incdir+source
source/dcache_pkg.sv
source/dcache_lookup.sv
source/dcache_controller.sv
source/dcache_miss_queue.sv
source/dcache_top.sv
testbench/dcache_assert.sv
testbench/dcache_tb.sv

// File: source/dcache_consts.svh
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// doubleword address, no byte offset bits
`define DCACHE_ADDR_BITS 16

// direct mapped, one doubleword per line
`define DCACHE_INDEX_BITS 5
`define DCACHE_LINES 32

// pending fills and evictions
`define DCACHE_MISS_DEPTH 4

`endif

// File: source/dcache_controller.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_controller (
  input  logic                                          clock,
  input  logic                                          reset,
  input  logic                                          lk_valid,
  input  logic                                          lk_store,
  input  logic [`DCACHE_ADDR_BITS-1:0]                  lk_addr,
  input  logic [63:0]                                   lk_data,
  input  logic                                          hit,
  input  logic [63:0]                                   hit_data,
  input  logic                                          victim_valid,
  input  logic                                          victim_dirty,
  input  logic [`DCACHE_ADDR_BITS-1:0]                  victim_addr,
  input  logic [63:0]                                   victim_data,
  input  logic                                          fill_valid,
  input  logic [`DCACHE_ADDR_BITS-1:0]                  fill_addr,
  input  logic [63:0]                                   fill_data,
  input  dcache_pkg::miss_kind_t                        fill_kind,
  input  logic                                          miss_empty,
  input  logic                                          miss_full,
  input  logic                                          flush,
  output logic                                          req_ready,
  output logic                                          hold,
  output logic                                          load_done,
  output logic [63:0]                                   load_data,
  output logic                                          store_done,
  output logic                                          wr_en,
  output logic [`DCACHE_INDEX_BITS-1:0]                 wr_index,
  output logic [`DCACHE_ADDR_BITS-`DCACHE_INDEX_BITS-1:0] wr_tag,
  output logic [63:0]                                   wr_data,
  output logic                                          wr_valid,
  output logic                                          wr_dirty,
  output logic                                          miss_push,
  output dcache_pkg::miss_kind_t                        miss_kind,
  output logic [`DCACHE_ADDR_BITS-1:0]                  miss_addr,
  output logic [63:0]                                   miss_data,
  output logic [`DCACHE_INDEX_BITS-1:0]                 flush_index,
  output logic                                          flush_active,
  output logic                                          halt
);
  localparam int AB = `DCACHE_ADDR_BITS;
  localparam int IB = `DCACHE_INDEX_BITS;

  typedef enum logic [1:0] {st_idle, st_walk, st_done} flush_state_t;

  flush_state_t  state;
  logic [IB-1:0] count;
  logic          miss_busy;
  logic          miss_second;
  logic          lk_used;
  logic          st_pend;
  logic          pend_store;
  logic [AB-1:0] pend_addr;
  logic [63:0]   pend_data;
  logic          proc;
  logic          proc_hit;
  logic          proc_miss;
  logic          evict_first;
  logic          walk_go;
  logic          walk_evict;

  assign req_ready = (state == st_idle) && !flush && !miss_busy;
  assign hold      = !req_ready;

  // captured request is handled once, and only with no miss outstanding
  assign proc        = lk_valid && !lk_used && !miss_busy;
  assign proc_hit    = proc && hit;
  assign proc_miss   = proc && !hit;
  assign evict_first = proc_miss && victim_valid && victim_dirty;

  // walk steps only when the write port and queue are free
  assign flush_active = (state == st_walk) && !proc;
  assign walk_go      = flush_active && !miss_busy && !miss_full && !st_pend;
  assign walk_evict   = walk_go && victim_valid && victim_dirty;
  assign flush_index  = count;
  assign halt         = (state == st_done) && miss_empty;

  // dirty victim goes first, the miss itself one cycle later
  always_comb begin
    miss_push = miss_second || proc_miss || walk_evict;
    if (miss_second) begin
      miss_kind = pend_store ? dcache_pkg::miss_store : dcache_pkg::miss_load;
      miss_addr = pend_addr;
      miss_data = pend_data;
    end else if (proc_miss && !evict_first) begin
      miss_kind = lk_store ? dcache_pkg::miss_store : dcache_pkg::miss_load;
      miss_addr = lk_addr;
      miss_data = lk_data;
    end else begin
      miss_kind = dcache_pkg::miss_evict;
      miss_addr = victim_addr;
      miss_data = victim_data;
    end
  end

  // write port: flush walk, then fill, then store hit
  always_comb begin
    wr_en = 1'b1;
    if (walk_go) begin
      wr_index = count;
      wr_tag   = victim_addr[AB-1:IB];
      wr_data  = victim_data;
      wr_valid = 1'b0;
      wr_dirty = 1'b0;
    end else if (fill_valid) begin
      wr_index = fill_addr[IB-1:0];
      wr_tag   = fill_addr[AB-1:IB];
      wr_data  = fill_data;
      wr_valid = 1'b1;
      wr_dirty = (fill_kind == dcache_pkg::miss_store);
    end else begin
      wr_en    = st_pend;
      wr_index = pend_addr[IB-1:0];
      wr_tag   = pend_addr[AB-1:IB];
      wr_data  = pend_data;
      wr_valid = 1'b1;
      wr_dirty = 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state       <= st_idle;
      count       <= '0;
      miss_busy   <= 1'b0;
      miss_second <= 1'b0;
      lk_used     <= 1'b0;
      st_pend     <= 1'b0;
      load_done   <= 1'b0;
      store_done  <= 1'b0;
    end else begin
      load_done   <= (proc_hit && !lk_store) ||
                     (fill_valid && fill_kind == dcache_pkg::miss_load);
      store_done  <= (proc_hit && lk_store) ||
                     (fill_valid && fill_kind == dcache_pkg::miss_store);
      st_pend     <= proc_hit && lk_store;
      miss_second <= evict_first;
      if (proc_miss) begin
        miss_busy <= 1'b1;
      end else if (fill_valid) begin
        miss_busy <= 1'b0;
      end
      if (!hold) begin
        lk_used <= 1'b0;
      end else if (proc) begin
        lk_used <= 1'b1;
      end
      if (walk_go) begin
        count <= count + 1'b1;
      end
      case (state)
        st_idle: if (flush) state <= st_walk;
        st_walk: if (walk_go && count == IB'(`DCACHE_LINES - 1)) state <= st_done;
        default: state <= state;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    load_data <= fill_valid ? fill_data : hit_data;
    if (proc) begin
      pend_store <= lk_store;
      pend_addr  <= lk_addr;
      pend_data  <= lk_data;
    end
  end

endmodule

// File: source/dcache_lookup.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_lookup (
  input  logic                                          clock,
  input  logic                                          reset,
  input  logic                                          req_valid,
  input  logic                                          req_store,
  input  logic [`DCACHE_ADDR_BITS-1:0]                  req_addr,
  input  logic [63:0]                                   req_data,
  input  logic                                          hold,
  input  logic                                          wr_en,
  input  logic [`DCACHE_INDEX_BITS-1:0]                 wr_index,
  input  logic [`DCACHE_ADDR_BITS-`DCACHE_INDEX_BITS-1:0] wr_tag,
  input  logic [63:0]                                   wr_data,
  input  logic                                          wr_valid,
  input  logic                                          wr_dirty,
  input  logic [`DCACHE_INDEX_BITS-1:0]                 flush_index,
  input  logic                                          flush_active,
  output logic                                          lk_valid,
  output logic                                          lk_store,
  output logic [`DCACHE_ADDR_BITS-1:0]                  lk_addr,
  output logic [63:0]                                   lk_data,
  output logic                                          hit,
  output logic [63:0]                                   hit_data,
  output logic                                          victim_valid,
  output logic                                          victim_dirty,
  output logic [`DCACHE_ADDR_BITS-1:0]                  victim_addr,
  output logic [63:0]                                   victim_data
);
  localparam int AB = `DCACHE_ADDR_BITS;
  localparam int IB = `DCACHE_INDEX_BITS;
  localparam int TB = AB - IB;

  logic [TB-1:0]            tag_array [`DCACHE_LINES];
  logic [63:0]              data_array [`DCACHE_LINES];
  logic [`DCACHE_LINES-1:0] valid_bits;
  logic [`DCACHE_LINES-1:0] dirty_bits;
  logic [IB-1:0]            rd_index;
  logic                     fwd;
  logic [TB-1:0]            line_tag;
  logic [63:0]              line_data;
  logic                     line_valid;
  logic                     line_dirty;

  // request stage, frozen while the controller stalls
  always_ff @(posedge clock) begin
    if (reset) begin
      lk_valid <= 1'b0;
    end else if (!hold) begin
      lk_valid <= req_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (!hold) begin
      lk_store <= req_store;
      lk_addr  <= req_addr;
      lk_data  <= req_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else if (wr_en) begin
      valid_bits[wr_index] <= wr_valid;
      dirty_bits[wr_index] <= wr_dirty;
    end
  end

  always_ff @(posedge clock) begin
    if (wr_en) begin
      tag_array[wr_index]  <= wr_tag;
      data_array[wr_index] <= wr_data;
    end
  end

  // flush walk reads its own line, otherwise the request's line
  assign rd_index = flush_active ? flush_index : lk_addr[IB-1:0];

  // store hit from the previous request lands this cycle
  assign fwd = wr_en && !flush_active && (wr_index == rd_index);

  assign line_valid = fwd ? wr_valid : valid_bits[rd_index];
  assign line_dirty = fwd ? wr_dirty : dirty_bits[rd_index];
  assign line_tag   = fwd ? wr_tag   : tag_array[rd_index];
  assign line_data  = fwd ? wr_data  : data_array[rd_index];

  assign hit      = line_valid && (line_tag == lk_addr[AB-1:IB]);
  assign hit_data = line_data;

  assign victim_valid = line_valid;
  assign victim_dirty = line_dirty;
  assign victim_addr  = {line_tag, rd_index};
  assign victim_data  = line_data;

endmodule

// File: source/dcache_miss_queue.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_miss_queue (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           miss_push,
  input  dcache_pkg::miss_kind_t         miss_kind,
  input  logic [`DCACHE_ADDR_BITS-1:0]   miss_addr,
  input  logic [63:0]                    miss_data,
  input  logic                           mem_response,
  input  logic [63:0]                    mem_rdata,
  output logic                           miss_empty,
  output logic                           miss_full,
  output dcache_pkg::mem_command_t       mem_command,
  output logic [`DCACHE_ADDR_BITS-1:0]   mem_addr,
  output logic [63:0]                    mem_wdata,
  output logic                           fill_valid,
  output logic [`DCACHE_ADDR_BITS-1:0]   fill_addr,
  output logic [63:0]                    fill_data,
  output dcache_pkg::miss_kind_t         fill_kind
);
  localparam int AB    = `DCACHE_ADDR_BITS;
  localparam int DEPTH = `DCACHE_MISS_DEPTH;
  localparam int PB    = $clog2(DEPTH);
  localparam int CB    = PB + 1;

  dcache_pkg::miss_kind_t kind_q [DEPTH];
  logic [AB-1:0]          addr_q [DEPTH];
  logic [63:0]            data_q [DEPTH];
  logic [PB-1:0]          head;
  logic [PB-1:0]          tail;
  logic [CB-1:0]          count;
  logic                   push;
  logic                   pop;

  assign miss_empty = (count == '0);
  assign miss_full  = (count == CB'(DEPTH));

  assign push = miss_push && !miss_full;
  assign pop  = mem_response && !miss_empty;

  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (push) begin
        tail <= (tail == PB'(DEPTH - 1)) ? '0 : tail + 1'b1;
      end
      if (pop) begin
        head <= (head == PB'(DEPTH - 1)) ? '0 : head + 1'b1;
      end
      count <= count + CB'(push) - CB'(pop);
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      kind_q[tail] <= miss_kind;
      addr_q[tail] <= miss_addr;
      data_q[tail] <= miss_data;
    end
  end

  // head entry stays on the bus until memory answers
  always_comb begin
    if (miss_empty) begin
      mem_command = dcache_pkg::bus_none;
    end else if (kind_q[head] == dcache_pkg::miss_evict) begin
      mem_command = dcache_pkg::bus_store;
    end else begin
      mem_command = dcache_pkg::bus_load;
    end
  end

  assign mem_addr  = addr_q[head];
  assign mem_wdata = data_q[head];

  // one word per line, so a store miss simply replaces the memory word
  assign fill_valid = pop && (kind_q[head] != dcache_pkg::miss_evict);
  assign fill_addr  = addr_q[head];
  assign fill_kind  = kind_q[head];
  assign fill_data  = (kind_q[head] == dcache_pkg::miss_store) ? data_q[head] : mem_rdata;

endmodule

// File: source/dcache_pkg.sv
package dcache_pkg;

  // memory port command, held until mem_response
  typedef enum logic [1:0] {
    bus_none  = 2'd0,
    bus_load  = 2'd1,
    bus_store = 2'd2
  } mem_command_t;

  // miss queue entry kind
  // load and store misses read memory, evictions write it
  typedef enum logic [1:0] {
    miss_load  = 2'd0,
    miss_store = 2'd1,
    miss_evict = 2'd2
  } miss_kind_t;

endpackage

// File: source/dcache_top.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_top (
  input  logic                                 clock,
  input  logic                                 reset,
  input  logic                                 req_valid,
  input  logic                                 req_store,
  input  logic [`DCACHE_ADDR_BITS-1:0]         req_addr,
  input  logic [63:0]                          req_data,
  output logic                                 req_ready,
  output logic                                 load_done,
  output logic [63:0]                          load_data,
  output logic                                 store_done,
  output dcache_pkg::mem_command_t             mem_command,
  output logic [`DCACHE_ADDR_BITS-1:0]         mem_addr,
  output logic [63:0]                          mem_wdata,
  input  logic                                 mem_response,
  input  logic [63:0]                          mem_rdata,
  input  logic                                 flush,
  output logic                                 halt
);
  // lookup stage to controller
  logic                                           lk_valid, lk_store, hit;
  logic [`DCACHE_ADDR_BITS-1:0]                   lk_addr, victim_addr;
  logic [63:0]                                    lk_data, hit_data, victim_data;
  logic                                           victim_valid, victim_dirty;

  // cache write port and flush read-out
  logic                                           hold, wr_en, wr_valid, wr_dirty;
  logic [`DCACHE_INDEX_BITS-1:0]                  wr_index, flush_index;
  logic [`DCACHE_ADDR_BITS-`DCACHE_INDEX_BITS-1:0] wr_tag;
  logic [63:0]                                    wr_data;
  logic                                           flush_active;

  // controller and miss queue
  logic                                           miss_push, miss_empty, miss_full;
  dcache_pkg::miss_kind_t                         miss_kind, fill_kind;
  logic [`DCACHE_ADDR_BITS-1:0]                   miss_addr, fill_addr;
  logic [63:0]                                    miss_data, fill_data;
  logic                                           fill_valid;

  dcache_lookup u_lookup (.*);

  dcache_controller u_controller (.*);

  dcache_miss_queue u_miss_queue (.*);

endmodule

// File: testbench/dcache_assert.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_assert (
  input logic                         clock,
  input logic                         reset,
  input logic                         miss_push,
  input logic                         miss_full,
  input logic                         miss_empty,
  input logic                         mem_response,
  input dcache_pkg::mem_command_t     mem_command,
  input logic [`DCACHE_ADDR_BITS-1:0] mem_addr
);

  // entries seen going in and answered on the memory port
  logic [3:0] occupancy;

  always_ff @(posedge clock) begin
    if (reset) begin
      occupancy <= '0;
    end else begin
      occupancy <= occupancy + 4'(miss_push && !miss_full)
                   - 4'(mem_response && mem_command != dcache_pkg::bus_none);
    end
  end

  // command and address hold until memory answers
  command_held: assert property (
    @(posedge clock) disable iff (reset)
    (mem_command != dcache_pkg::bus_none && !mem_response)
      |=> ($stable(mem_command) && $stable(mem_addr))
  ) else $error("memory command changed before mem_response");

  idle_when_empty: assert property (
    @(posedge clock) disable iff (reset)
    (occupancy == '0) |-> (miss_empty && mem_command == dcache_pkg::bus_none)
  ) else $error("memory command issued from an empty miss queue");

  no_push_when_full: assert property (
    @(posedge clock) disable iff (reset)
    !(miss_push && miss_full)
  ) else $error("miss_push while the miss queue is full");

endmodule

bind dcache_miss_queue dcache_assert u_assert (
  .clock        (clock),
  .reset        (reset),
  .miss_push    (miss_push),
  .miss_full    (miss_full),
  .miss_empty   (miss_empty),
  .mem_response (mem_response),
  .mem_command  (mem_command),
  .mem_addr     (mem_addr)
);

// File: testbench/dcache_tb.sv
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_tb;
  localparam int          AB             = `DCACHE_ADDR_BITS;
  localparam int          TIMEOUT_CYCLES = 12000;
  localparam logic [31:0] SEED           = 32'h3639_13a1;

  logic                     clock = 1'b0;
  logic                     reset;
  logic                     req_valid;
  logic                     req_store;
  logic [AB-1:0]            req_addr;
  logic [63:0]              req_data;
  logic                     req_ready;
  logic                     load_done;
  logic [63:0]              load_data;
  logic                     store_done;
  dcache_pkg::mem_command_t mem_command;
  logic [AB-1:0]            mem_addr;
  logic [63:0]              mem_wdata;
  logic                     mem_response = 1'b0;
  logic [63:0]              mem_rdata = '0;
  logic                     flush;
  logic                     halt;

  // memory model
  logic [63:0]   mem_model [1 << AB];
  logic          mem_busy;
  logic [1:0]    mem_wait;
  logic [31:0]   mem_rand;
  int            rd_count;
  int            wb_count;
  logic [AB-1:0] last_wb_addr;
  logic [63:0]   last_wb_data;

  // reference state, expected loads kept in request order
  logic [63:0]   shadow [1 << AB];
  logic [63:0]   exp_data_q [$];
  logic [AB-1:0] exp_addr_q [$];
  logic [AB-1:0] touched_q [$];
  int            loads_sent;
  int            stores_sent;
  int            loads_seen;
  int            stores_seen;
  int            cycle_count = 0;
  logic [31:0]   stim_rand;
  bit            verdict_printed = 1'b0;

  dcache_top u_dut (.*);

  always #4 clock = ~clock;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // every field depends on the full address
  function automatic logic [63:0] init_word(input logic [AB-1:0] a);
    return {a ^ 16'hc3a5, ~a, a + 16'h1234, a};
  endfunction

  function automatic logic [63:0] ref_load(input logic [AB-1:0] a);
    return shadow[a];
  endfunction

  task automatic abort_run();
    verdict_printed = 1'b1;
    $display("TEST FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  // hold the request until the cache takes it, then book the expected result
  task automatic issue_request(input logic store, input logic [AB-1:0] addr,
                               input logic [63:0] data);
    req_valid <= 1'b1;
    req_store <= store;
    req_addr  <= addr;
    req_data  <= data;
    @(posedge clock);
    while (!req_ready) begin
      @(posedge clock);
    end
    touched_q.push_back(addr);
    if (store) begin
      shadow[addr] = data;
      stores_sent  = stores_sent + 1;
    end else begin
      exp_data_q.push_back(ref_load(addr));
      exp_addr_q.push_back(addr);
      loads_sent = loads_sent + 1;
    end
  endtask

  task automatic wait_quiet();
    req_valid <= 1'b0;
    @(posedge clock);
    while (loads_seen != loads_sent || stores_seen != stores_sent) begin
      @(posedge clock);
    end
  endtask

  // answers the head command after 1 to 4 cycles
  always @(posedge clock) begin
    if (reset) begin
      mem_response <= 1'b0;
      mem_busy     <= 1'b0;
      mem_wait     <= 2'd0;
      mem_rand     = SEED;
      rd_count     = 0;
      wb_count     = 0;
      for (int a = 0; a < (1 << AB); a++) begin
        mem_model[AB'(a)] = init_word(AB'(a));
      end
    end else begin
      mem_response <= 1'b0;
      if (!mem_response && mem_command != dcache_pkg::bus_none) begin
        if (!mem_busy) begin
          mem_rand = lcg_next(mem_rand);
          mem_busy <= 1'b1;
          mem_wait <= mem_rand[17:16];
        end else if (mem_wait != 2'd0) begin
          mem_wait <= mem_wait - 2'd1;
        end else begin
          mem_busy     <= 1'b0;
          mem_response <= 1'b1;
          if (mem_command == dcache_pkg::bus_store) begin
            mem_model[mem_addr] = mem_wdata;
            wb_count     = wb_count + 1;
            last_wb_addr = mem_addr;
            last_wb_data = mem_wdata;
          end else begin
            mem_rdata <= mem_model[mem_addr];
            rd_count  = rd_count + 1;
          end
        end
      end
    end
  end

  // response compare
  always @(posedge clock) begin
    if (reset) begin
      loads_seen  <= 0;
      stores_seen <= 0;
    end else begin
      if (load_done) begin
        assert (exp_data_q.size() > 0) else begin
          $display("load_done pulsed with no load outstanding");
          abort_run();
        end
        assert (load_data == exp_data_q[0]) else begin
          $display("[FAIL] load_data = %h, expected %h (address %h)",
                   load_data, exp_data_q[0], exp_addr_q[0]);
          abort_run();
        end
        void'(exp_data_q.pop_front());
        void'(exp_addr_q.pop_front());
        loads_seen <= loads_seen + 1;
      end
      if (store_done) begin
        assert (stores_seen < stores_sent) else begin
          $display("store_done pulsed with no store outstanding");
          abort_run();
        end
        stores_seen <= stores_seen + 1;
      end
    end
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  initial begin
    logic [AB-1:0] addr;
    logic [63:0]   data;
    logic          op;
    int            rd_before;
    int            wb_before;

    reset       <= 1'b1;
    req_valid   <= 1'b0;
    req_store   <= 1'b0;
    req_addr    <= '0;
    req_data    <= '0;
    flush       <= 1'b0;
    stim_rand   = SEED;
    loads_sent  = 0;
    stores_sent = 0;
    for (int a = 0; a < (1 << AB); a++) begin
      shadow[AB'(a)] = init_word(AB'(a));
    end
    repeat (2) @(posedge clock);
    reset <= 1'b0;

    // cold load misses, the repeat hits
    rd_before = rd_count;
    issue_request(1'b0, 16'h0200, '0);
    wait_quiet();
    assert (rd_count == rd_before + 1) else begin
      $display("first load of 0200 did not read memory");
      abort_run();
    end
    issue_request(1'b0, 16'h0200, '0);
    wait_quiet();
    assert (rd_count == rd_before + 1) else begin
      $display("second load of 0200 went to memory instead of hitting");
      abort_run();
    end

    // store hit, then store miss with allocation
    rd_before = rd_count;
    issue_request(1'b1, 16'h0200, 64'h0123_4567_89ab_cdef);
    issue_request(1'b0, 16'h0200, '0);
    issue_request(1'b1, 16'h0333, 64'hfeed_face_0333_0001);
    issue_request(1'b0, 16'h0333, '0);
    wait_quiet();
    assert (rd_count == rd_before + 1) else begin
      $display("store miss did not allocate, or a hit read memory");
      abort_run();
    end

    // same index, other tag, dirty line goes back to memory
    wb_before = wb_count;
    issue_request(1'b1, 16'h0105, 64'hdead_beef_0105_c0de);
    issue_request(1'b0, 16'h0125, '0);
    wait_quiet();
    assert (wb_count == wb_before + 1) else begin
      $display("conflicting load did not write back the dirty line");
      abort_run();
    end
    assert (last_wb_addr == 16'h0105 && last_wb_data == 64'hdead_beef_0105_c0de) else begin
      $display("[FAIL] mem_addr = %h, mem_wdata = %h, expected 0105 and deadbeef0105c0de",
               last_wb_addr, last_wb_data);
      abort_run();
    end
    issue_request(1'b0, 16'h0105, '0);
    wait_quiet();

    // random mix over 64 words, twice the line count
    for (int i = 0; i < 500; i++) begin
      stim_rand = lcg_next(stim_rand);
      if (stim_rand[31:29] == 3'd0) begin
        req_valid <= 1'b0;
        @(posedge clock);
      end
      addr      = 16'h0800 + {10'd0, stim_rand[21:16]};
      op        = stim_rand[26];
      stim_rand = lcg_next(stim_rand);
      data      = {stim_rand, stim_rand ^ 32'h5a5a_0f0f};
      issue_request(op, addr, data);
    end
    wait_quiet();

    flush <= 1'b1;
    @(posedge clock);
    flush <= 1'b0;
    while (!halt) begin
      assert (!req_ready) else begin
        $display("[FAIL] req_ready = %h during flush, expected 0", req_ready);
        abort_run();
      end
      @(posedge clock);
    end
    repeat (16) begin
      @(posedge clock);
      assert (halt && !req_ready) else begin
        $display("[FAIL] halt = %h, req_ready = %h after halt, expected 1 and 0",
                 halt, req_ready);
        abort_run();
      end
    end

    // every dirty word must have reached memory
    foreach (touched_q[i]) begin
      assert (mem_model[touched_q[i]] == shadow[touched_q[i]]) else begin
        $display("[FAIL] mem_model[%h] = %h, expected %h",
                 touched_q[i], mem_model[touched_q[i]], shadow[touched_q[i]]);
        abort_run();
      end
    end

    if (loads_seen == loads_sent && stores_seen == stores_sent) begin
      verdict_printed = 1'b1;
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("done pulses (%0d loads, %0d stores) differ from requests (%0d, %0d)",
               loads_seen, stores_seen, loads_sent, stores_sent);
      abort_run();
    end
  end

  // run ended without a verdict, e.g. stopped by a bound assertion
  final begin
    if (!verdict_printed) begin
      $display("TEST FAILED");
    end
  end

endmodule
